// ==== Bender.yml ====
package:
  name: core_top

sources:
  - files:
      - verilog/core_pkg.sv
      - verilog/fetch_unit.sv
      - verilog/decode_unit.sv
      - verilog/alu_unit.sv
      - verilog/mul_unit.sv
      - verilog/writeback_unit.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/core_tb.sv

// ==== bench/core_tb_ref.svh ====
`ifndef CORE_TB_REF_SVH
`define CORE_TB_REF_SVH

////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////

// Fixed seed keeps every run identical
logic [31:0] lcg_state = 32'd5931;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

////////////////////////////////////////////////////////////
// Architectural model of the toy ISA
////////////////////////////////////////////////////////////

logic [31:0] model_rf [16];
logic [31:0] model_pc;

// All registers zero, PC at address 0
task automatic reset_model();
    for (int i = 0; i < 16; i++) begin
        model_rf[i] = '0;
    end
    model_pc = '0;
endtask

// Executes one word, returns what retire should show
function automatic retire_t step_model(input logic [31:0] word);
    retire_t     exp;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] next_pc;
    op      = word[31:28];
    rd      = word[27:24];
    a       = model_rf[word[23:20]];
    b       = model_rf[word[19:16]];
    // ADDI and BEQ both sign-extend the low half
    imm     = {{16{word[15]}}, word[15:0]};
    next_pc = model_pc + 32'd4;
    exp       = '0;
    exp.valid = 1'b1;
    exp.pc    = model_pc;
    exp.rd    = rd;
    exp.we    = 1'b1;
    case (op)
        op_add:  exp.value = a + b;
        op_sub:  exp.value = a - b;
        op_and:  exp.value = a & b;
        op_or:   exp.value = a | b;
        op_xor:  exp.value = a ^ b;
        op_addi: exp.value = a + imm;
        // Low 32 bits of the product
        op_mul:  exp.value = a * b;
        op_beq: begin
            // Compares rs1 against rd, offset counted in words
            exp.we = 1'b0;
            if (a == model_rf[rd]) begin
                next_pc = model_pc + (imm << 2);
            end
        end
        default: exp.value = '0;
    endcase
    // r0 keeps reading zero
    if (exp.we && rd != 4'd0) begin
        model_rf[rd] = exp.value;
    end
    model_pc = next_pc;
    return exp;
endfunction

`endif

// ==== bench/core_tb.sv ====
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();

    logic        clock;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    retire_t     retire;

    // Word-addressed program image
    logic [31:0] prog_mem [256];
    int          prog_len;
    logic [31:0] halt_pc;
    int          err_count;
    int          retire_count;
    logic        done;
    // Bus slave state
    logic        ack_pending;
    logic [31:0] wait_left;

    `include "core_tb_ref.svh"

    // 4 ns period
    always #2 clock = ~clock;

    core_top i_dut (
        .clock  ( clock  ),
        .arst_n ( arst_n ),
        .wb_req ( wb_req ),
        .wb_rsp ( wb_rsp ),
        .retire ( retire )
    );

    ////////////////////////////////////////////////////////////
    // Program construction
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] reg_instr(input logic [3:0] op, input logic [3:0] rd,
                                              input logic [3:0] rs1, input logic [3:0] rs2);
        return {op, rd, rs1, rs2, 16'h0000};
    endfunction

    // For BEQ the rd field names the second compare register
    function automatic logic [31:0] imm_instr(input logic [3:0] op, input logic [3:0] rd,
                                              input logic [3:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, 4'h0, imm};
    endfunction

    task automatic append_word(input logic [31:0] word);
        prog_mem[prog_len] = word;
        prog_len++;
    endtask

    // Fields taken from the upper LCG bits
    task automatic append_random_alu();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  op;
        r  = lcg_next();
        s  = lcg_next();
        op = r[19:16] % 4'd6;
        if (op == op_addi) begin
            append_word(imm_instr(op, r[31:28], r[27:24], s[31:16]));
        end else begin
            append_word(reg_instr(op, r[31:28], r[27:24], r[23:20]));
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  rd;
        prog_len = 0;
        // Seed r1..r8 with random immediates of either sign
        for (int i = 1; i < 9; i++) begin
            r = lcg_next();
            append_word(imm_instr(op_addi, i[3:0], 4'd0, r[31:16]));
        end
        repeat (32) begin
            append_random_alu();
        end
        // MUL with dependents right behind it
        repeat (4) begin
            r  = lcg_next();
            s  = lcg_next();
            rd = (r[31:28] == 4'd0) ? 4'd9 : r[31:28];
            append_word(reg_instr(op_mul, rd, r[27:24], r[23:20]));
            append_word(reg_instr(op_add, s[31:28], rd, 4'd0));
            append_word(reg_instr(op_mul, s[27:24], rd, rd));
            append_word(reg_instr(op_sub, s[23:20], rd, s[31:28]));
        end
        // Counted loop with r1 running 3 down to 0
        append_word(imm_instr(op_addi, 4'd1, 4'd0, 16'd3));
        append_word(imm_instr(op_addi, 4'd2, 4'd0, 16'd0));
        append_word(imm_instr(op_addi, 4'd3, 4'd0, 16'd1));
        append_word(imm_instr(op_addi, 4'd4, 4'd0, 16'd2));
        append_word(imm_instr(op_addi, 4'd1, 4'd1, 16'hffff));
        append_word(imm_instr(op_addi, 4'd2, 4'd2, 16'd5));
        // Exit when r1 hits zero, else jump back three words
        append_word(imm_instr(op_beq, 4'd0, 4'd1, 16'd2));
        append_word(imm_instr(op_beq, 4'd0, 4'd0, 16'hfffd));
        // Unequal backward BEQ falls through
        append_word(imm_instr(op_beq, 4'd4, 4'd3, 16'hfffc));
        // Equal forward BEQ skips the ADDI
        append_word(imm_instr(op_beq, 4'd3, 4'd3, 16'd2));
        append_word(imm_instr(op_addi, 4'd5, 4'd0, 16'd99));
        // Branch waiting on a product
        append_word(reg_instr(op_mul, 4'd7, 4'd4, 4'd3));
        append_word(imm_instr(op_beq, 4'd4, 4'd7, 16'd2));
        append_word(imm_instr(op_addi, 4'd5, 4'd0, 16'd77));
        append_word(reg_instr(op_add, 4'd6, 4'd2, 4'd7));
        // Branch to itself ends the program
        halt_pc = prog_len * 4;
        append_word(imm_instr(op_beq, 4'd0, 4'd0, 16'h0000));
    endtask

    // ADD r0,r0,r0 past the end of the program
    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (addr[31:2] < prog_len) begin
            return prog_mem[addr[31:2]];
        end
        return 32'h0000_0000;
    endfunction

    ////////////////////////////////////////////////////////////
    // Wishbone slave with random ack delay
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!arst_n) begin
            wb_rsp      <= '0;
            ack_pending = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            // 0 to 3 wait cycles per read
            if (!ack_pending) begin
                ack_pending = 1'b1;
                wait_left   = lcg_next() >> 30;
            end
            if (wait_left == 0) begin
                wb_rsp.ack  <= 1'b1;
                wb_rsp.dat  <= mem_read(wb_req.adr);
                ack_pending = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Retire compare
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin : compare_retire
        retire_t     exp;
        logic [31:0] word;
        if (arst_n && retire.valid && !done) begin
            word = mem_read(model_pc);
            exp  = step_model(word);
            retire_count++;
            if (retire.pc !== exp.pc) begin
                err_count++;
                $display("ERR %0t retire.pc expected %h actual %h", $time, exp.pc, retire.pc);
            end
            if (retire.rd !== exp.rd) begin
                err_count++;
                $display("ERR %0t retire.rd expected %h actual %h", $time, exp.rd, retire.rd);
            end
            if (retire.we !== exp.we) begin
                err_count++;
                $display("ERR %0t retire.we expected %b actual %b", $time, exp.we, retire.we);
            end
            // Branches carry no result value
            if (exp.we && retire.value !== exp.value) begin
                err_count++;
                $display("ERR %0t retire.value expected %h actual %h",
                         $time, exp.value, retire.value);
            end
            if (exp.pc == halt_pc) begin
                done = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset, run and report
    ////////////////////////////////////////////////////////////

    initial begin : main_flow
        int cycles;
        int total;
        int last_count;
        clock        = 1'b0;
        arst_n       = 1'b0;
        wb_rsp       = '0;
        err_count    = 0;
        retire_count = 0;
        done         = 1'b0;
        reset_model();
        build_program();
        // Bus and retire quiet through reset
        repeat (10) begin
            @(negedge clock);
            if (wb_req.cyc !== 1'b0) begin
                err_count++;
                $display("ERR %0t wb_req.cyc expected 0 actual %b", $time, wb_req.cyc);
            end
            if (wb_req.stb !== 1'b0) begin
                err_count++;
                $display("ERR %0t wb_req.stb expected 0 actual %b", $time, wb_req.stb);
            end
            if (retire.valid !== 1'b0) begin
                err_count++;
                $display("ERR %0t retire.valid expected 0 actual %b", $time, retire.valid);
            end
        end
        arst_n = 1'b1;
        // First read after release
        cycles = 0;
        while (wb_req.cyc !== 1'b1 && cycles < 50) begin
            @(negedge clock);
            cycles++;
        end
        if (wb_req.cyc !== 1'b1) begin
            err_count++;
            $display("The first bus request did not start after reset was released");
        end else if (wb_req.adr !== 32'h0) begin
            err_count++;
            $display("ERR %0t wb_req.adr expected %h actual %h", $time, 32'h0, wb_req.adr);
        end
        // Each retire gets its own window inside an overall bound
        cycles     = 0;
        total      = 0;
        last_count = retire_count;
        while (!done && cycles < 200 && total < 20000) begin
            @(posedge clock);
            total++;
            if (retire_count != last_count) begin
                last_count = retire_count;
                cycles     = 0;
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            err_count++;
            if (cycles >= 200) begin
                $display("No instruction retired in time, the run stopped waiting");
            end else begin
                $display("The program did not reach its final branch in time");
            end
        end
        $display("Errors: %0d, instructions retired: %0d", err_count, retire_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== core_top.f ====
+incdir+bench
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/writeback_unit.sv
verilog/core_top.sv
bench/core_tb.sv

// ==== verilog/alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit import core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  issue_t  issue,
    output result_t result,
    output branch_t branch
);

    logic [xlen-1:0] value;
    logic [xlen-1:0] target;
    logic            equal;

    // BEQ operands are rs1 and rd
    assign equal  = (issue.a == issue.b);
    // Word offset relative to the branch itself
    assign target = issue.pc + {{(xlen-imm_w-2){issue.imm[imm_w-1]}}, issue.imm, 2'b00};

    always_comb begin
        case (issue.op)
            op_sub:  value = issue.a - issue.b;
            op_and:  value = issue.a & issue.b;
            op_or:   value = issue.a | issue.b;
            op_xor:  value = issue.a ^ issue.b;
            // No register result
            op_beq:  value = '0;
            // ADD, and ADDI with b already extended
            default: value = issue.a + issue.b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Execute to write-back register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            branch <= '0;
        end else begin
            result.valid  <= issue.valid;
            result.pc     <= issue.pc;
            result.rd     <= issue.rd;
            result.we     <= issue.we;
            result.value  <= value;
            // Single-cycle redirect pulse
            branch.taken  <= issue.valid & (issue.op == op_beq) & equal;
            branch.target <= target;
        end
    end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////////////////////////
    // Core widths and latencies
    ////////////////////////////////////////////////////////////

    // Data and address width
    localparam int xlen       = 32;
    // Architectural registers, r0 hardwired to zero
    localparam int num_regs   = 16;
    localparam int reg_w      = $clog2(num_regs);
    // Immediate field of the I format
    localparam int imm_w      = 16;
    // Multiplier latency in cycles
    localparam int mul_stages = 3;

    // Toy ISA opcodes, top nibble of the word
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_mul,
        op_beq
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    // Register-register view
    typedef struct packed {
        opcode_e          op;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] rs1;
        logic [reg_w-1:0] rs2;
        logic [15:0]      unused;
    } r_fmt_t;

    // Immediate view, ADDI and BEQ
    typedef struct packed {
        opcode_e          op;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] rs1;
        logic [3:0]       pad;
        logic [imm_w-1:0] imm16;
    } i_fmt_t;

    // Same fetched word, two decodings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    ////////////////////////////////////////////////////////////
    // Bus and stage records
    ////////////////////////////////////////////////////////////

    // Wishbone classic master side, reads only
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [xlen-1:0] adr;
    } wb_req_t;

    // Wishbone classic slave side
    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_t          instr;
    } fetch_t;

    // Issued op, imm only carries the BEQ offset
    typedef struct packed {
        logic             valid;
        opcode_e          op;
        logic [xlen-1:0]  pc;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
        logic             we;
        logic [imm_w-1:0] imm;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [xlen-1:0]  pc;
        logic [reg_w-1:0] rd;
        logic             we;
        logic [xlen-1:0]  value;
    } result_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } branch_t;

    typedef struct packed {
        logic [reg_w-1:0] addr1;
        logic [reg_w-1:0] addr2;
    } rf_read_t;

    typedef struct packed {
        logic [xlen-1:0] data1;
        logic [xlen-1:0] data2;
    } rf_data_t;

    // Retire port carries a plain result
    typedef result_t retire_t;

endpackage

// ==== verilog/core_top.sv ====
`timescale 1ns/100ps

module core_top import core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output retire_t retire
);

    // Fetch to decode
    fetch_t           fetch;
    logic             stall;
    // Register file ports
    rf_read_t         rf_read;
    rf_data_t         rf_data;
    logic             wb_clear;
    logic [reg_w-1:0] wb_clear_rd;
    // Execute side
    issue_t           alu_issue;
    issue_t           mul_issue;
    result_t          alu_result;
    result_t          mul_result;
    branch_t          branch;
    logic             mul_busy;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    fetch_unit i_fetch (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .wb_req      ( wb_req      ),
        .wb_rsp      ( wb_rsp      ),
        .branch      ( branch      ),
        .stall       ( stall       ),
        .fetch       ( fetch       )
    );

    ////////////////////////////////////////////////////////////
    // Decode and execute
    ////////////////////////////////////////////////////////////

    decode_unit i_decode (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .fetch       ( fetch       ),
        .stall       ( stall       ),
        .rf_read     ( rf_read     ),
        .rf_data     ( rf_data     ),
        .branch      ( branch      ),
        .mul_busy    ( mul_busy    ),
        .wb_clear    ( wb_clear    ),
        .wb_clear_rd ( wb_clear_rd ),
        .alu_issue   ( alu_issue   ),
        .mul_issue   ( mul_issue   )
    );

    alu_unit i_alu (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .issue       ( alu_issue   ),
        .result      ( alu_result  ),
        .branch      ( branch      )
    );

    mul_unit i_mul (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .issue       ( mul_issue   ),
        .result      ( mul_result  ),
        .busy        ( mul_busy    )
    );

    ////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////

    writeback_unit i_writeback (
        .clock       ( clock       ),
        .arst_n      ( arst_n      ),
        .alu_result  ( alu_result  ),
        .mul_result  ( mul_result  ),
        .rf_read     ( rf_read     ),
        .rf_data     ( rf_data     ),
        .wb_clear    ( wb_clear    ),
        .wb_clear_rd ( wb_clear_rd ),
        .retire      ( retire      )
    );

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit import core_pkg::*; (
    input  logic             clock,
    input  logic             arst_n,
    input  fetch_t           fetch,
    output logic             stall,
    output rf_read_t         rf_read,
    input  rf_data_t         rf_data,
    input  branch_t          branch,
    input  logic             mul_busy,
    input  logic             wb_clear,
    input  logic [reg_w-1:0] wb_clear_rd,
    output issue_t           alu_issue,
    output issue_t           mul_issue
);

    instr_t              ins;
    opcode_e             op;
    logic [reg_w-1:0]    rd;
    logic [xlen-1:0]     imm_sext;
    logic                src2_used;
    logic                dst_write;
    logic                hazard;
    logic                accept;
    logic                squash;
    logic                issue_ok;
    logic [num_regs-1:1] pending_q;
    logic [num_regs-1:0] busy_regs;
    issue_t              issue_q;

    ////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////

    assign ins       = fetch.instr;
    assign op        = ins.r_fmt.op;
    assign rd        = ins.r_fmt.rd;
    assign imm_sext  = {{(xlen-imm_w){ins.i_fmt.imm16[imm_w-1]}}, ins.i_fmt.imm16};
    // ADDI reads rs1 only
    assign src2_used = (op != op_addi);
    // BEQ writes nothing
    assign dst_write = (op != op_beq);

    // BEQ compares rs1 against rd
    assign rf_read.addr1 = ins.r_fmt.rs1;
    assign rf_read.addr2 = (op == op_beq) ? rd : ins.r_fmt.rs2;

    ////////////////////////////////////////////////////////////
    // Scoreboard and stall
    ////////////////////////////////////////////////////////////

    // Value landing this cycle is forwarded and not busy
    always_comb begin
        busy_regs = {pending_q, 1'b0};
        if (wb_clear) begin
            busy_regs[wb_clear_rd] = 1'b0;
        end
    end

    assign hazard = busy_regs[rf_read.addr1] | (src2_used & busy_regs[rf_read.addr2]);
    // Nothing may issue behind a multiply
    assign stall  = (fetch.valid & hazard) | mul_busy | mul_issue.valid;
    assign accept = fetch.valid & ~stall & ~branch.taken;
    // Wrong-path op sitting in the issue register
    assign squash = branch.taken & issue_q.valid & issue_q.we;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= '0;
        end else begin
            for (int i = 1; i < num_regs; i++) begin
                if (accept && dst_write && rd == i) begin
                    pending_q[i] <= 1'b1;
                end else if ((wb_clear && wb_clear_rd == i) || (squash && issue_q.rd == i)) begin
                    pending_q[i] <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue_q <= '0;
        end else begin
            // Branch also empties it since accept drops
            issue_q.valid <= accept;
            if (accept) begin
                issue_q.op  <= op;
                issue_q.pc  <= fetch.pc;
                issue_q.rd  <= rd;
                issue_q.a   <= rf_data.data1;
                issue_q.b   <= (op == op_addi) ? imm_sext : rf_data.data2;
                issue_q.we  <= dst_write;
                issue_q.imm <= ins.i_fmt.imm16;
            end
        end
    end

    // Masked during a redirect
    assign issue_ok = issue_q.valid & ~branch.taken;

    // MUL goes to the multiplier and the rest to the ALU
    always_comb begin
        alu_issue       = issue_q;
        alu_issue.valid = issue_ok & (issue_q.op != op_mul);
        mul_issue       = issue_q;
        mul_issue.valid = issue_ok & (issue_q.op == op_mul);
    end

    // ALU never issues beside or behind a running multiply
    a_one_issue: assert property (@(posedge clock) disable iff (!arst_n)
        alu_issue.valid |-> !mul_issue.valid && !mul_busy);

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    input  branch_t branch,
    input  logic    stall,
    output fetch_t  fetch
);

    // Bus master state
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_drop
    } state_e;

    state_e          state_q;
    logic [xlen-1:0] pc_q;
    logic            consume;
    logic            launch;

    // Decode takes the held word
    assign consume = fetch.valid & ~stall;
    // New read once the buffer is free or freeing up
    assign launch  = (state_q == st_idle) & ~branch.taken & (~fetch.valid | consume);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            pc_q    <= '0;
            wb_req  <= '0;
            fetch   <= '0;
        end else begin
            if (consume) begin
                fetch.valid <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (launch) begin
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.adr <= pc_q;
                        pc_q       <= pc_q + 4;
                        state_q    <= st_wait;
                    end
                end
                st_wait: begin
                    if (wb_rsp.ack) begin
                        // Data captured in the ack cycle
                        wb_req.cyc  <= 1'b0;
                        wb_req.stb  <= 1'b0;
                        fetch.valid <= 1'b1;
                        fetch.pc    <= wb_req.adr;
                        fetch.instr <= wb_rsp.dat;
                        state_q     <= st_idle;
                    end else if (branch.taken) begin
                        // Read overtaken by a branch is finished and thrown away
                        state_q <= st_drop;
                    end
                end
                st_drop: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        state_q    <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
            // Redirect wins over any buffered or returning word
            if (branch.taken) begin
                pc_q        <= branch.target;
                fetch.valid <= 1'b0;
            end
        end
    end

    // Classic handshake holds cyc, stb and adr until ack
    a_adr_hold: assert property (@(posedge clock) disable iff (!arst_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.cyc && wb_req.stb && $stable(wb_req.adr));

endmodule

// ==== verilog/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit import core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  issue_t  issue,
    output result_t result,
    output logic    busy
);

    result_t         stage_q [mul_stages];
    logic [xlen-1:0] product;

    // Low half only
    assign product = issue.a * issue.b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mul_stages; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0].valid <= issue.valid;
            stage_q[0].pc    <= issue.pc;
            stage_q[0].rd    <= issue.rd;
            stage_q[0].we    <= issue.we;
            stage_q[0].value <= product;
            // Tag travels with the product
            for (int i = 1; i < mul_stages; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Busy while any stage is occupied
    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < mul_stages; i++) begin
            busy = busy | stage_q[i].valid;
        end
    end

    assign result = stage_q[mul_stages-1];

    // Decode must hold issue until the pipe drains
    a_no_issue_busy: assert property (@(posedge clock) disable iff (!arst_n)
        busy |-> !issue.valid);

endmodule

// ==== verilog/writeback_unit.sv ====
`timescale 1ns/100ps

module writeback_unit import core_pkg::*; (
    input  logic             clock,
    input  logic             arst_n,
    input  result_t          alu_result,
    input  result_t          mul_result,
    input  rf_read_t         rf_read,
    output rf_data_t         rf_data,
    output logic             wb_clear,
    output logic [reg_w-1:0] wb_clear_rd,
    output retire_t          retire
);

    logic [xlen-1:0] rf_q [num_regs];
    result_t         merged;
    logic            wr_en;

    // At most one source valid per cycle
    assign merged = alu_result.valid ? alu_result : mul_result;
    // r0 never written, stays zero
    assign wr_en  = merged.valid & merged.we & (merged.rd != '0);

    ////////////////////////////////////////////////////////////
    // Register file and retire register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                rf_q[i] <= '0;
            end
            retire <= '0;
        end else begin
            if (wr_en) begin
                rf_q[merged.rd] <= merged.value;
            end
            retire <= merged;
        end
    end

    // Read ports see the write of this cycle
    always_comb begin
        rf_data.data1 = rf_q[rf_read.addr1];
        rf_data.data2 = rf_q[rf_read.addr2];
        if (wr_en && merged.rd == rf_read.addr1) begin
            rf_data.data1 = merged.value;
        end
        if (wr_en && merged.rd == rf_read.addr2) begin
            rf_data.data2 = merged.value;
        end
    end

    // Scoreboard drop, same cycle as forwarding
    assign wb_clear    = merged.valid & merged.we;
    assign wb_clear_rd = merged.rd;

    a_one_result: assert property (@(posedge clock) disable iff (!arst_n)
        !(alu_result.valid && mul_result.valid));

endmodule
